// File: design/ddr_test_pkg.sv
`default_nettype none

package ddr_test_pkg;

  localparam int DATA_WIDTH       = 128;  // one controller data beat
  localparam int ADDR_WIDTH       = 31;
  localparam int BURST_STEP_SHIFT = 2;    // low address bits zero per burst
  localparam int CNT_WIDTH        = 16;   // burst and error counts
  localparam int BUF_DEPTH        = 4;    // capture fifo depth in bursts
  localparam int BUF_PTR_WIDTH    = $clog2(BUF_DEPTH);
  localparam int BUF_LVL_WIDTH    = $clog2(BUF_DEPTH + 1);

  // register word addresses
  localparam logic [1:0] REG_CTRL   = 2'd0;
  localparam logic [1:0] REG_COUNT  = 2'd1;
  localparam logic [1:0] REG_STATUS = 2'd2;
  localparam logic [1:0] REG_ERRORS = 2'd3;

  typedef enum logic [1:0] {PATT_ONES = 2'd0, PATT_ADDR = 2'd1, PATT_NADDR = 2'd2} pattern_mode_e;

  typedef struct packed {
    logic                  rd_we_n;  // 1 read, 0 write
    logic [ADDR_WIDTH-1:0] addr;
    logic                  valid;    // address fifo write enable
  } ddr_cmd_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  valid;    // data fifo write enable
  } ddr_wdata_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  dvalid;   // marks beat 0
  } ddr_rdata_t;

  typedef struct packed {
    pattern_mode_e        mode;
    logic [CNT_WIDTH-1:0] burst_count;
  } test_cfg_t;

  typedef struct packed {
    logic                 busy;
    logic                 done;
    logic                 pass;
    logic [CNT_WIDTH-1:0] errors;
  } test_status_t;

  // controller address of burst k
  function automatic logic [ADDR_WIDTH-1:0] burst_addr(input logic [CNT_WIDTH-1:0] idx);
    return ADDR_WIDTH'(idx) << BURST_STEP_SHIFT;
  endfunction

  // both beats of a burst carry the same word
  function automatic logic [DATA_WIDTH-1:0] pattern_word(input pattern_mode_e mode,
                                                         input logic [ADDR_WIDTH-1:0] addr);
    logic [31:0] word;
    word = 32'(addr);
    case (mode)
      PATT_ADDR:  return {(DATA_WIDTH/32){word}};
      PATT_NADDR: return ~{(DATA_WIDTH/32){word}};
      default:    return '1;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: design/harness_regs.sv
`timescale 1ns/100ps
`default_nettype none

module harness_regs import ddr_test_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst_n_i,
  input  wire logic         wb_cyc_i,
  input  wire logic         wb_stb_i,
  input  wire logic         wb_we_i,
  input  wire logic [1:0]   wb_sel_i,
  input  wire logic [31:0]  wb_adr_i,
  input  wire logic [15:0]  wb_dat_i,
  input  wire test_status_t status_i,
  output logic [15:0]       wb_dat_o,
  output logic              wb_ack_o,
  output test_cfg_t         cfg_o,
  output logic              start_o
);

  logic                 access;
  logic                 cfg_lock;
  logic                 start_req;  // start pulse pending
  logic [1:0]           reg_sel;
  logic [15:0]          rd_word;
  pattern_mode_e        mode_q;
  logic [CNT_WIDTH-1:0] count_q;

  assign reg_sel  = wb_adr_i[1:0];                     // word address
  assign access   = wb_cyc_i & wb_stb_i & ~wb_ack_o;   // idle cycle between acks
  assign cfg_lock = status_i.busy | start_req | start_o;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_ack_o  <= 1'b0;
      start_req <= 1'b0;
      start_o   <= 1'b0;
      mode_q    <= PATT_ONES;
      count_q   <= '0;
    end else begin
      wb_ack_o  <= access;
      start_req <= access & wb_we_i & wb_sel_i[0] & (reg_sel == REG_CTRL) &
                   wb_dat_i[0] & ~status_i.busy;
      start_o   <= start_req & ~status_i.busy;  // one cycle after the ack
      // config is frozen while a test runs
      if (access && wb_we_i && !cfg_lock) begin
        if (reg_sel == REG_CTRL && wb_sel_i[0]) begin
          mode_q <= pattern_mode_e'(wb_dat_i[2:1]);
        end
        if (reg_sel == REG_COUNT) begin
          if (wb_sel_i[0]) begin
            count_q[7:0] <= wb_dat_i[7:0];
          end
          if (wb_sel_i[1]) begin
            count_q[15:8] <= wb_dat_i[15:8];
          end
        end
      end
    end
  end

  always_comb begin
    case (reg_sel)
      REG_CTRL:   rd_word = {13'd0, mode_q, 1'b0};  // start reads as 0
      REG_COUNT:  rd_word = 16'(count_q);
      REG_STATUS: rd_word = {13'd0, status_i.pass, status_i.done, status_i.busy};
      default:    rd_word = 16'(status_i.errors);
    endcase
  end

  // read data goes out with the ack
  always_ff @(posedge clk) begin
    if (access && !wb_we_i) begin
      wb_dat_o <= rd_word;
    end
  end

  assign cfg_o = '{mode: mode_q, burst_count: count_q};

  ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

// File: design/pattern_writer.sv
`timescale 1ns/100ps
`default_nettype none

module pattern_writer import ddr_test_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     rst_n_i,
  input  wire logic                     start_i,
  input  wire test_cfg_t                cfg_i,
  input  wire logic                     af_afull_i,
  input  wire logic                     df_afull_i,
  input  wire logic [BUF_LVL_WIDTH-1:0] credit_i,
  input  wire logic                     checker_done_i,
  output ddr_cmd_t                      cmd_o,
  output ddr_wdata_t                    wdata_o,
  output logic                          busy_o
);

  typedef enum logic [2:0] {IDLE, WR_BEAT0, WR_BEAT1, RD_ISSUE, WAIT_CHECK} state_e;

  state_e                state;
  logic [CNT_WIDTH-1:0]  idx;  // burst index for both passes
  logic [ADDR_WIDTH-1:0] addr;
  logic                  last_burst;
  logic                  wr_go;
  logic                  rd_go;

  assign addr       = burst_addr(idx);
  assign last_burst = (idx == cfg_i.burst_count - 1'b1);

  // commands only leave at a burst boundary
  assign wr_go = (state == WR_BEAT0) & ~af_afull_i & ~df_afull_i;
  assign rd_go = (state == RD_ISSUE) & ~af_afull_i & (credit_i != '0);

  always_comb begin
    cmd_o.rd_we_n = (state != WR_BEAT0);
    cmd_o.addr    = addr;
    cmd_o.valid   = wr_go | rd_go;
    wdata_o.data  = pattern_word(cfg_i.mode, addr);  // same word for both beats
    wdata_o.valid = wr_go | (state == WR_BEAT1);     // beat 1 never waits
  end

  assign busy_o = (state != IDLE);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state <= IDLE;
      idx   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start_i) begin
            idx   <= '0;
            state <= (cfg_i.burst_count == '0) ? WAIT_CHECK : WR_BEAT0;
          end
        end
        WR_BEAT0: begin
          if (wr_go) begin
            state <= WR_BEAT1;
          end
        end
        WR_BEAT1: begin
          if (last_burst) begin
            idx   <= '0;  // read pass starts over at burst 0
            state <= RD_ISSUE;
          end else begin
            idx   <= idx + 1'b1;
            state <= WR_BEAT0;
          end
        end
        RD_ISSUE: begin
          if (rd_go) begin
            if (last_burst) begin
              state <= WAIT_CHECK;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        WAIT_CHECK: begin
          if (checker_done_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  beat1_after_wr_cmd: assert property (@(posedge clk) disable iff (!rst_n_i)
    (cmd_o.valid && !cmd_o.rd_we_n) |=> (wdata_o.valid && !cmd_o.valid));

  no_cmd_on_afull: assert property (@(posedge clk) disable iff (!rst_n_i)
    af_afull_i |-> !cmd_o.valid);

endmodule

`default_nettype wire

// File: design/read_capture_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module read_capture_fifo import ddr_test_pkg::*; (
  input  wire logic                      clk,
  input  wire logic                      rst_n_i,
  input  wire ddr_rdata_t                rdata_i,
  input  wire logic                      rd_issue_i,
  input  wire logic                      pop_i,
  output logic [2*DATA_WIDTH-1:0]        burst_o,
  output logic                           avail_o,
  output logic [BUF_LVL_WIDTH-1:0]       credit_o
);

  logic [2*DATA_WIDTH-1:0]  mem [BUF_DEPTH];
  logic [DATA_WIDTH-1:0]    beat0_q;
  logic                     beat1_pend;   // beat 1 on the bus this cycle
  logic                     wr_en;
  logic [BUF_PTR_WIDTH-1:0] wr_ptr;
  logic [BUF_PTR_WIDTH-1:0] rd_ptr;
  logic [BUF_LVL_WIDTH-1:0] level;        // stored bursts
  logic [BUF_LVL_WIDTH-1:0] outstanding;  // reads issued, not yet stored

  assign wr_en = beat1_pend;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beat1_pend  <= 1'b0;
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      level       <= '0;
      outstanding <= '0;
    end else begin
      beat1_pend <= rdata_i.dvalid;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      level       <= level + BUF_LVL_WIDTH'(wr_en) - BUF_LVL_WIDTH'(pop_i);
      // a read stops being outstanding once its burst is stored
      outstanding <= outstanding + BUF_LVL_WIDTH'(rd_issue_i) - BUF_LVL_WIDTH'(wr_en);
    end
  end

  always_ff @(posedge clk) begin
    if (rdata_i.dvalid) begin
      beat0_q <= rdata_i.data;
    end
    if (wr_en) begin
      mem[wr_ptr] <= {rdata_i.data, beat0_q};  // beat 0 in the low half
    end
  end

  assign burst_o  = mem[rd_ptr];
  assign avail_o  = (level != '0);
  assign credit_o = BUF_LVL_WIDTH'(BUF_DEPTH) - level - outstanding;

  no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_en |-> (level < BUF_DEPTH));

endmodule

`default_nettype wire

// File: design/read_checker.sv
`timescale 1ns/100ps
`default_nettype none

module read_checker import ddr_test_pkg::*; (
  input  wire logic                    clk,
  input  wire logic                    rst_n_i,
  input  wire logic                    start_i,
  input  wire test_cfg_t               cfg_i,
  input  wire logic [2*DATA_WIDTH-1:0] burst_i,
  input  wire logic                    avail_i,
  output logic                         pop_o,
  output logic [CNT_WIDTH-1:0]         errors_o,
  output logic                         done_o,
  output logic                         pass_o
);

  logic [CNT_WIDTH-1:0]  chk_idx;  // reads return in order
  logic [DATA_WIDTH-1:0] exp_word;
  logic                  mismatch;
  logic                  last_burst;

  assign pop_o      = avail_i;
  assign exp_word   = pattern_word(cfg_i.mode, burst_addr(chk_idx));
  assign mismatch   = (burst_i != {exp_word, exp_word});  // both beats at once
  assign last_burst = (chk_idx == cfg_i.burst_count - 1'b1);
  assign pass_o     = done_o & (errors_o == '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      chk_idx  <= '0;
      errors_o <= '0;
      done_o   <= 1'b0;
    end else if (start_i) begin
      chk_idx  <= '0;
      errors_o <= '0;
      done_o   <= (cfg_i.burst_count == '0);  // nothing to check
    end else if (pop_o && !done_o) begin
      chk_idx <= chk_idx + 1'b1;
      // saturating count of bad bursts
      if (mismatch && errors_o != '1) begin
        errors_o <= errors_o + 1'b1;
      end
      if (last_burst) begin
        done_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/ddr_test_harness.sv
`timescale 1ns/100ps
`default_nettype none

module ddr_test_harness import ddr_test_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n_i,
  input  wire logic        wb_cyc_i,
  input  wire logic        wb_stb_i,
  input  wire logic        wb_we_i,
  input  wire logic [1:0]  wb_sel_i,
  input  wire logic [31:0] wb_adr_i,
  input  wire logic [15:0] wb_dat_i,
  input  wire logic        ddr_af_afull_i,
  input  wire logic        ddr_df_afull_i,
  input  wire ddr_rdata_t  ddr_rdata_i,
  output logic [15:0]      wb_dat_o,
  output logic             wb_ack_o,
  output ddr_cmd_t         ddr_cmd_o,
  output ddr_wdata_t       ddr_wdata_o
);

  test_cfg_t                cfg;
  test_status_t             status;
  logic                     start;
  logic                     busy;
  logic                     rd_issue;
  logic [BUF_LVL_WIDTH-1:0] credit;
  logic [2*DATA_WIDTH-1:0]  burst;
  logic                     avail;
  logic                     pop;
  logic [CNT_WIDTH-1:0]     errors;
  logic                     done;
  logic                     pass;

  assign rd_issue = ddr_cmd_o.valid & ddr_cmd_o.rd_we_n;  // read commands take credit
  assign status   = '{busy: busy, done: done, pass: pass, errors: errors};

  harness_regs u_regs (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_sel_i (wb_sel_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .status_i (status),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .cfg_o    (cfg),
    .start_o  (start)
  );

  pattern_writer u_writer (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .start_i        (start),
    .cfg_i          (cfg),
    .af_afull_i     (ddr_af_afull_i),
    .df_afull_i     (ddr_df_afull_i),
    .credit_i       (credit),
    .checker_done_i (done),
    .cmd_o          (ddr_cmd_o),
    .wdata_o        (ddr_wdata_o),
    .busy_o         (busy)
  );

  read_capture_fifo u_capture (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rdata_i    (ddr_rdata_i),
    .rd_issue_i (rd_issue),
    .pop_i      (pop),
    .burst_o    (burst),
    .avail_o    (avail),
    .credit_o   (credit)
  );

  read_checker u_checker (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .start_i  (start),
    .cfg_i    (cfg),
    .burst_i  (burst),
    .avail_i  (avail),
    .pop_o    (pop),
    .errors_o (errors),
    .done_o   (done),
    .pass_o   (pass)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;  // 20 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #2 rst_n_o = 1'b1;  // released off the edge like other inputs
  end

endmodule

`default_nettype wire

// File: tests/ddr_ctrl_model.sv
`timescale 1ns/100ps
`default_nettype none

module ddr_ctrl_model import ddr_test_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n_i,
  input  wire logic        clr_i,        // clears counters between rows
  input  wire logic        fault_en_i,
  input  wire logic [15:0] fault_idx_i,
  input  wire ddr_cmd_t    cmd_i,
  input  wire ddr_wdata_t  wdata_i,
  output logic             af_afull_o,
  output logic             df_afull_o,
  output ddr_rdata_t       rdata_o
);

  localparam int MEM_BURSTS = 64;
  localparam int RD_LATENCY = 3;

  logic [DATA_WIDTH-1:0] mem0 [MEM_BURSTS];  // beat 0 per burst
  logic [DATA_WIDTH-1:0] mem1 [MEM_BURSTS];  // beat 1 per burst
  int                    wr_cnt;
  int                    rd_cnt;
  int                    beat_cnt;
  int                    order_errs;  // commands out of sequence
  int                    cycle;
  int                    rd_q [$];
  int                    rd_due [$];
  integer                seed = 95;
  logic                  wr_pend;
  int                    wr_idx;
  logic                  ret_beat1;
  logic [DATA_WIDTH-1:0] ret_data1;
  logic [DATA_WIDTH-1:0] d0;
  logic [31:0]           r;
  ddr_rdata_t            nxt;
  int                    idx;
  int                    k;

  initial begin
    af_afull_o = 1'b0;
    df_afull_o = 1'b0;
    rdata_o    = '0;
  end

  always @(posedge clk) begin
    nxt = '0;
    if (!rst_n_i || clr_i) begin
      wr_cnt     = 0;
      rd_cnt     = 0;
      beat_cnt   = 0;
      order_errs = 0;
      wr_pend    = 1'b0;
      ret_beat1  = 1'b0;
      rd_q.delete();
      rd_due.delete();
    end else begin
      cycle++;
      if (wdata_i.valid) beat_cnt++;
      if (wr_pend && wdata_i.valid) mem1[wr_idx] = wdata_i.data;  // beat 1
      wr_pend = 1'b0;
      if (cmd_i.valid) begin
        idx = int'(cmd_i.addr >> BURST_STEP_SHIFT) % MEM_BURSTS;
        if (cmd_i.rd_we_n) begin
          if (int'(cmd_i.addr) != (rd_cnt << BURST_STEP_SHIFT)) order_errs++;
          rd_q.push_back(idx);
          rd_due.push_back(cycle + RD_LATENCY);
          rd_cnt++;
        end else begin
          if (int'(cmd_i.addr) != (wr_cnt << BURST_STEP_SHIFT)) order_errs++;
          if (wdata_i.valid) mem0[idx] = wdata_i.data;  // beat 0 rides with the command
          wr_pend = 1'b1;
          wr_idx  = idx;
          wr_cnt++;
        end
      end
      // returns go out one two-beat burst at a time
      if (ret_beat1) begin
        nxt       = '{data: ret_data1, dvalid: 1'b0};
        ret_beat1 = 1'b0;
      end else if (rd_q.size() != 0 && rd_due[0] <= cycle) begin
        k = rd_q.pop_front();
        void'(rd_due.pop_front());
        d0 = mem0[k];
        if (fault_en_i && k == int'(fault_idx_i)) begin
          d0[0] = ~d0[0];  // corrupt on the way back only
        end
        nxt       = '{data: d0, dvalid: 1'b1};
        ret_data1 = mem1[k];
        ret_beat1 = 1'b1;
      end
    end
    #2;
    r          = $random(seed);
    af_afull_o = rst_n_i & (r[1:0] == 2'b00);
    r          = $random(seed);
    df_afull_o = rst_n_i & (r[1:0] == 2'b00);
    rdata_o    = nxt;
  end

endmodule

`default_nettype wire

// File: tests/ddr_test_harness_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ddr_test_harness_tb import ddr_test_pkg::*; ();

  localparam int NUM_ROWS = 5;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_sel;
  logic [31:0] wb_adr;
  logic [15:0] wb_dat_w;
  logic [15:0] wb_dat_r;
  logic        wb_ack;
  logic        af_afull;
  logic        df_afull;
  logic        clr;
  logic        fault_en;
  logic [15:0] fault_idx;
  ddr_rdata_t  rdata;
  ddr_cmd_t    cmd;
  ddr_wdata_t  wdata;

  // stimulus table
  string         row_name [NUM_ROWS];
  pattern_mode_e row_mode [NUM_ROWS];
  int            row_count [NUM_ROWS];
  int            row_fault [NUM_ROWS];  // -1 for no fault
  bit            row_busy_start [NUM_ROWS];

  int checks;
  int errors;
  int accesses;
  int ack_cnt;
  int cycles;
  int limit;

  tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  ddr_ctrl_model u_model (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .clr_i       (clr),
    .fault_en_i  (fault_en),
    .fault_idx_i (fault_idx),
    .cmd_i       (cmd),
    .wdata_i     (wdata),
    .af_afull_o  (af_afull),
    .df_afull_o  (df_afull),
    .rdata_o     (rdata)
  );

  ddr_test_harness UUT (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .wb_cyc_i       (wb_cyc),
    .wb_stb_i       (wb_stb),
    .wb_we_i        (wb_we),
    .wb_sel_i       (wb_sel),
    .wb_adr_i       (wb_adr),
    .wb_dat_i       (wb_dat_w),
    .ddr_af_afull_i (af_afull),
    .ddr_df_afull_i (df_afull),
    .ddr_rdata_i    (rdata),
    .wb_dat_o       (wb_dat_r),
    .wb_ack_o       (wb_ack),
    .ddr_cmd_o      (cmd),
    .ddr_wdata_o    (wdata)
  );

  always @(posedge clk) begin
    if (wb_ack) ack_cnt++;
    cycles++;
    if (cycles >= limit) begin
      $display("timed out waiting for done after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // both beats of burst k carry this word
  function automatic logic [DATA_WIDTH-1:0] expected_word(input pattern_mode_e mode,
                                                          input int k);
    logic [31:0] a;
    a = 32'(k) << BURST_STEP_SHIFT;
    case (mode)
      PATT_ADDR:  return {(DATA_WIDTH/32){a}};
      PATT_NADDR: return ~{(DATA_WIDTH/32){a}};
      default:    return {DATA_WIDTH{1'b1}};
    endcase
  endfunction

  task automatic cmp_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_burst(input string name, input ddr_wdata_t exp, input ddr_wdata_t act);
    checks++;
    if (act.data !== exp.data) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp.data, act.data);
    end
  endtask

  task automatic cmp_status(input string name, input test_status_t exp,
                            input test_status_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      // busy/done/pass/errors
      $display("error %s: expected %b/%b/%b/%0d, actual %b/%b/%b/%0d", name,
               exp.busy, exp.done, exp.pass, exp.errors,
               act.busy, act.done, act.pass, act.errors);
    end
  endtask

  // single register access up to its ack
  task automatic reg_access(input logic we, input logic [1:0] adr, input logic [15:0] wdat,
                            output logic [15:0] rdat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_sel   = 2'b11;
    wb_adr   = 32'(adr);
    wb_dat_w = wdat;
    accesses++;
    @(posedge clk);
    #2;
    while (!wb_ack) begin
      @(posedge clk);
      #2;
    end
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic reg_write(input logic [1:0] adr, input logic [15:0] wdat);
    logic [15:0] unused;
    reg_access(1'b1, adr, wdat, unused);
  endtask

  task automatic reg_read(input logic [1:0] adr, output logic [15:0] rdat);
    reg_access(1'b0, adr, 16'd0, rdat);
  endtask

  task automatic set_row(input int i, input string name, input pattern_mode_e mode,
                         input int count, input int fault, input bit busy_start);
    row_name[i]       = name;
    row_mode[i]       = mode;
    row_count[i]      = count;
    row_fault[i]      = fault;
    row_busy_start[i] = busy_start;
  endtask

  task automatic run_row(input int r);
    logic [15:0]   d;
    logic [15:0]   e;
    int            exp_err;
    int            acc0;
    int            ack0;
    test_status_t  exp_s;
    test_status_t  act_s;
    ddr_wdata_t    exp_b;
    ddr_wdata_t    act_b;
    pattern_mode_e other;
    exp_err   = (row_fault[r] >= 0) ? 1 : 0;
    other     = (row_mode[r] == PATT_ONES) ? PATT_ADDR : PATT_ONES;
    clr       = 1'b1;
    fault_en  = (row_fault[r] >= 0);
    fault_idx = (row_fault[r] >= 0) ? 16'(row_fault[r]) : 16'd0;
    @(posedge clk);
    #2;
    clr  = 1'b0;
    acc0 = accesses;
    ack0 = ack_cnt;
    reg_write(REG_COUNT, 16'(row_count[r]));
    reg_write(REG_CTRL, {13'd0, row_mode[r], 1'b0});
    reg_read(REG_COUNT, d);
    cmp_word({row_name[r], " count readback"}, 16'(row_count[r]), d);
    reg_write(REG_CTRL, {13'd0, row_mode[r], 1'b1});
    d = '0;
    while (!d[0]) reg_read(REG_STATUS, d);  // done may still be stale here
    if (row_busy_start[r]) begin
      // restart would lose the checker's place in the read pass
      while (u_model.rd_cnt < row_count[r] / 2) begin
        @(posedge clk);
        #2;
      end
      reg_write(REG_CTRL, {13'd0, other, 1'b1});  // must be ignored
    end
    d = '0;
    while (!d[1]) reg_read(REG_STATUS, d);
    reg_read(REG_STATUS, d);
    reg_read(REG_ERRORS, e);
    act_s = '{busy: d[0], done: d[1], pass: d[2], errors: e};
    exp_s = '{busy: 1'b0, done: 1'b1, pass: (exp_err == 0), errors: CNT_WIDTH'(exp_err)};
    cmp_status({row_name[r], " status"}, exp_s, act_s);
    reg_read(REG_CTRL, d);
    cmp_word({row_name[r], " mode readback"}, {13'd0, row_mode[r], 1'b0}, d);
    cmp_word({row_name[r], " write commands"}, 16'(row_count[r]), 16'(u_model.wr_cnt));
    cmp_word({row_name[r], " read commands"}, 16'(row_count[r]), 16'(u_model.rd_cnt));
    cmp_word({row_name[r], " data beats"}, 16'(2 * row_count[r]), 16'(u_model.beat_cnt));
    cmp_word({row_name[r], " address order"}, 16'd0, 16'(u_model.order_errs));
    for (int k = 0; k < row_count[r]; k++) begin
      exp_b = '{data: expected_word(row_mode[r], k), valid: 1'b1};
      act_b = '{data: u_model.mem0[k], valid: 1'b1};
      cmp_burst($sformatf("%s burst %0d beat 0", row_name[r], k), exp_b, act_b);
      act_b = '{data: u_model.mem1[k], valid: 1'b1};
      cmp_burst($sformatf("%s burst %0d beat 1", row_name[r], k), exp_b, act_b);
    end
    @(posedge clk);  // let the last ack be counted
    #2;
    cmp_word({row_name[r], " acks"}, 16'(accesses - acc0), 16'(ack_cnt - ack0));
  endtask

  initial begin
    int total;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_sel    = 2'b00;
    wb_adr    = '0;
    wb_dat_w  = '0;
    clr       = 1'b0;
    fault_en  = 1'b0;
    fault_idx = '0;
    set_row(0, "ones_clean",  PATT_ONES,  16, -1, 1'b0);
    set_row(1, "addr_clean",  PATT_ADDR,  24, -1, 1'b0);
    set_row(2, "naddr_busy",  PATT_NADDR, 20, -1, 1'b1);
    set_row(3, "ones_fault",  PATT_ONES,  12,  5, 1'b0);
    set_row(4, "addr_fault",  PATT_ADDR,   9,  0, 1'b0);
    total = 0;
    for (int i = 0; i < NUM_ROWS; i++) total += row_count[i];
    limit = 40 * total + 2000;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #2;
    for (int i = 0; i < NUM_ROWS; i++) run_row(i);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
design/ddr_test_pkg.sv
design/harness_regs.sv
design/pattern_writer.sv
design/read_capture_fifo.sv
design/read_checker.sv
design/ddr_test_harness.sv
tests/tb_clock_gen.sv
tests/ddr_ctrl_model.sv
tests/ddr_test_harness_tb.sv

// File: Bender.yml
package:
  name: ddr_test_harness

sources:
  - files:
      - design/ddr_test_pkg.sv
      - design/harness_regs.sv
      - design/pattern_writer.sv
      - design/read_capture_fifo.sv
      - design/read_checker.sv
      - design/ddr_test_harness.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/ddr_ctrl_model.sv
      - tests/ddr_test_harness_tb.sv
